// ==== ahb_mem_subsys.f ====
hw/ahb_pkg.sv
hw/mem_pkg.sv
hw/sram_bank.sv
hw/ahb_sram_bridge.sv
hw/ahb_addr_decoder.sv
hw/ahb_mem_subsys.sv
sim/tb_clock_gen.sv
sim/tb_ahb_mem_subsys.sv

// ==== hw/ahb_addr_decoder.sv ====
`default_nettype none

module ahb_addr_decoder (
  input  wire logic              clk,
  input  wire logic              i_reset,
  input  wire logic              i_hsel,
  input  wire ahb_pkg::ahb_req_t i_req,
  input  wire ahb_pkg::ahb_rsp_t i_rsp_itcm,
  input  wire ahb_pkg::ahb_rsp_t i_rsp_dtcm,
  input  wire ahb_pkg::ahb_rsp_t i_rsp_sram,
  output logic                   o_sel_itcm,
  output logic                   o_sel_dtcm,
  output logic                   o_sel_sram,
  output logic                   o_hready,
  output ahb_pkg::ahb_rsp_t      o_rsp
);

  mem_pkg::region_t aph_region;
  mem_pkg::region_t dph_region;
  logic             accept;
  logic             err_first;
  logic             err_second;

  // --------------------------------------------------
  // Address phase decode
  // --------------------------------------------------
  always_comb begin
    case (i_req.haddr[31:28])
      mem_pkg::REGION_ITCM: aph_region = mem_pkg::ITCM;
      mem_pkg::REGION_DTCM: aph_region = mem_pkg::DTCM;
      mem_pkg::REGION_SRAM: aph_region = mem_pkg::SRAM;
      default:              aph_region = mem_pkg::NONE;
    endcase
  end

  assign o_sel_itcm = i_hsel && (aph_region == mem_pkg::ITCM);
  assign o_sel_dtcm = i_hsel && (aph_region == mem_pkg::DTCM);
  assign o_sel_sram = i_hsel && (aph_region == mem_pkg::SRAM);

  assign accept = i_hsel && o_hready &&
                  (i_req.htrans == ahb_pkg::HTRANS_NONSEQ ||
                   i_req.htrans == ahb_pkg::HTRANS_SEQ);

  // Data phase owner, plus the two-cycle error of the default slave
  always_ff @(posedge clk) begin
    if (i_reset) begin
      dph_region <= mem_pkg::NONE;
      err_first  <= 1'b0;
      err_second <= 1'b0;
    end else begin
      if (o_hready) begin
        dph_region <= accept ? aph_region : mem_pkg::NONE;
      end
      err_first  <= accept && (aph_region == mem_pkg::NONE);
      err_second <= err_first;
    end
  end

  // --------------------------------------------------
  // Response mux
  // --------------------------------------------------
  always_comb begin
    case (dph_region)
      mem_pkg::ITCM: o_rsp = i_rsp_itcm;
      mem_pkg::DTCM: o_rsp = i_rsp_dtcm;
      mem_pkg::SRAM: o_rsp = i_rsp_sram;
      default: begin
        // IDLE or BUSY leaves this at OKAY
        o_rsp.hrdata    = '0;
        o_rsp.hreadyout = !err_first;
        o_rsp.hresp     = err_first || err_second;
      end
    endcase
  end

  assign o_hready = o_rsp.hreadyout;

  // Stalled error cycle must complete as ERROR with ready high
  assert property (@(posedge clk) disable iff (i_reset)
    (dph_region == mem_pkg::NONE && !o_rsp.hreadyout) |=>
      (o_rsp.hresp && o_rsp.hreadyout));

endmodule

`default_nettype wire

// ==== hw/ahb_mem_subsys.sv ====
`default_nettype none

module ahb_mem_subsys #(
  parameter int ITCM_AW = 12,
  parameter int DTCM_AW = 12,
  parameter int SRAM_AW = 14
) (
  input  wire logic              clk,
  input  wire logic              i_reset,
  input  wire logic              i_hsel,
  input  wire ahb_pkg::ahb_req_t i_ahb,
  output ahb_pkg::ahb_rsp_t      o_ahb
);

  logic                       sel_itcm;
  logic                       sel_dtcm;
  logic                       sel_sram;
  logic                       hready;
  ahb_pkg::ahb_rsp_t          rsp_itcm;
  ahb_pkg::ahb_rsp_t          rsp_dtcm;
  ahb_pkg::ahb_rsp_t          rsp_sram;
  mem_pkg::sram_cmd_t         cmd_itcm;
  mem_pkg::sram_cmd_t         cmd_dtcm;
  mem_pkg::sram_cmd_t         cmd_sram;
  logic [ahb_pkg::DATA_W-1:0] rdata_itcm;
  logic [ahb_pkg::DATA_W-1:0] rdata_dtcm;
  logic [ahb_pkg::DATA_W-1:0] rdata_sram;

  ahb_addr_decoder u_decoder (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_hsel     (i_hsel),
    .i_req      (i_ahb),
    .i_rsp_itcm (rsp_itcm),
    .i_rsp_dtcm (rsp_dtcm),
    .i_rsp_sram (rsp_sram),
    .o_sel_itcm (sel_itcm),
    .o_sel_dtcm (sel_dtcm),
    .o_sel_sram (sel_sram),
    .o_hready   (hready),
    .o_rsp      (o_ahb)
  );

  // --------------------------------------------------
  // ITCM
  // --------------------------------------------------
  ahb_sram_bridge #(.AW(ITCM_AW)) u_bridge_itcm (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_sel    (sel_itcm),
    .i_hready (hready),
    .i_req    (i_ahb),
    .o_rsp    (rsp_itcm),
    .o_cmd    (cmd_itcm),
    .i_rdata  (rdata_itcm)
  );

  sram_bank #(.AW(ITCM_AW)) u_bank_itcm (
    .clk     (clk),
    .i_cmd   (cmd_itcm),
    .o_rdata (rdata_itcm)
  );

  // --------------------------------------------------
  // DTCM
  // --------------------------------------------------
  ahb_sram_bridge #(.AW(DTCM_AW)) u_bridge_dtcm (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_sel    (sel_dtcm),
    .i_hready (hready),
    .i_req    (i_ahb),
    .o_rsp    (rsp_dtcm),
    .o_cmd    (cmd_dtcm),
    .i_rdata  (rdata_dtcm)
  );

  sram_bank #(.AW(DTCM_AW)) u_bank_dtcm (
    .clk     (clk),
    .i_cmd   (cmd_dtcm),
    .o_rdata (rdata_dtcm)
  );

  // --------------------------------------------------
  // SRAM
  // --------------------------------------------------
  ahb_sram_bridge #(.AW(SRAM_AW)) u_bridge_sram (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_sel    (sel_sram),
    .i_hready (hready),
    .i_req    (i_ahb),
    .o_rsp    (rsp_sram),
    .o_cmd    (cmd_sram),
    .i_rdata  (rdata_sram)
  );

  sram_bank #(.AW(SRAM_AW)) u_bank_sram (
    .clk     (clk),
    .i_cmd   (cmd_sram),
    .o_rdata (rdata_sram)
  );

endmodule

`default_nettype wire

// ==== hw/ahb_pkg.sv ====
`default_nettype none

package ahb_pkg;

  // --------------------------------------------------
  // Bus widths
  // --------------------------------------------------
  localparam int DATA_W = 32;

  // --------------------------------------------------
  // AHB-Lite transfer encodings
  // --------------------------------------------------
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_t;

  typedef enum logic [2:0] {
    HSIZE_BYTE = 3'b000,
    HSIZE_HALF = 3'b001,
    HSIZE_WORD = 3'b010
  } hsize_t;

  // Master side, address phase fields plus data phase write data
  typedef struct packed {
    logic [31:0]       haddr;
    htrans_t           htrans;
    logic              hwrite;
    hsize_t            hsize;
    logic [DATA_W-1:0] hwdata;
  } ahb_req_t;

  // Slave side response
  typedef struct packed {
    logic [DATA_W-1:0] hrdata;
    logic              hreadyout;
    logic              hresp;
  } ahb_rsp_t;

endpackage

`default_nettype wire

// ==== hw/ahb_sram_bridge.sv ====
`default_nettype none

module ahb_sram_bridge #(
  parameter int AW = 12
) (
  input  wire logic                       clk,
  input  wire logic                       i_reset,
  input  wire logic                       i_sel,
  input  wire logic                       i_hready,
  input  wire ahb_pkg::ahb_req_t          i_req,
  output ahb_pkg::ahb_rsp_t               o_rsp,
  output mem_pkg::sram_cmd_t              o_cmd,
  input  wire logic [ahb_pkg::DATA_W-1:0] i_rdata
);

  logic                       trans_valid;
  logic                       rd_req;
  logic                       wr_req;
  logic [29:0]                word_addr;
  logic [3:0]                 lanes;

  // Write address phase, data arrives one cycle later
  logic                       wph_valid;
  logic [29:0]                wph_addr;
  logic [3:0]                 wph_lanes;
  logic                       wr_end;

  // One-entry write buffer
  logic                       buf_valid;
  logic [29:0]                buf_addr;
  logic [3:0]                 buf_lanes;
  logic [ahb_pkg::DATA_W-1:0] buf_data;
  logic                       buf_load;
  logic                       buf_hit;
  logic                       commit_buf;
  logic                       commit_direct;

  logic [29:0]                rd_addr_q;
  logic [ahb_pkg::DATA_W-1:0] merged;

  function automatic logic [3:0] size_lanes(input ahb_pkg::hsize_t size,
                                            input logic [1:0] offset);
    logic [3:0] mask;
    case (size)
      ahb_pkg::HSIZE_BYTE: mask = 4'b0001 << offset;
      ahb_pkg::HSIZE_HALF: mask = offset[1] ? 4'b1100 : 4'b0011;
      default:             mask = 4'b1111;
    endcase
    return mask;
  endfunction

  // --------------------------------------------------
  // Address phase
  // --------------------------------------------------
  assign trans_valid = i_sel && i_hready &&
                       (i_req.htrans == ahb_pkg::HTRANS_NONSEQ ||
                        i_req.htrans == ahb_pkg::HTRANS_SEQ);
  assign rd_req    = trans_valid && !i_req.hwrite;
  assign wr_req    = trans_valid && i_req.hwrite;
  // Offset bits above AW alias
  assign word_addr = 30'(i_req.haddr[AW-1:2]);
  assign lanes     = size_lanes(i_req.hsize, i_req.haddr[1:0]);

  // --------------------------------------------------
  // Write scheduling
  // --------------------------------------------------
  assign wr_end        = wph_valid && i_hready;
  assign commit_buf    = buf_valid && !rd_req;
  // Write data phase with a free RAM goes straight through
  assign commit_direct = wr_end && !rd_req && !buf_valid;
  assign buf_load      = wr_end && !commit_direct;

  always_comb begin
    o_cmd.cs    = 1'b0;
    o_cmd.wen   = 4'b0000;
    o_cmd.addr  = buf_addr;
    o_cmd.wdata = buf_data;
    if (rd_req) begin
      o_cmd.cs   = 1'b1;
      o_cmd.addr = word_addr;
    end else if (commit_buf) begin
      o_cmd.cs  = 1'b1;
      o_cmd.wen = buf_lanes;
    end else if (commit_direct) begin
      o_cmd.cs    = 1'b1;
      o_cmd.wen   = wph_lanes;
      o_cmd.addr  = wph_addr;
      o_cmd.wdata = i_req.hwdata;
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      wph_valid <= 1'b0;
      buf_valid <= 1'b0;
    end else begin
      if (i_hready) begin
        wph_valid <= wr_req;
      end
      if (buf_load) begin
        buf_valid <= 1'b1;
      end else if (commit_buf) begin
        buf_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_req) begin
      wph_addr  <= word_addr;
      wph_lanes <= lanes;
    end
    if (rd_req) begin
      rd_addr_q <= word_addr;
    end
    if (buf_load) begin
      buf_addr  <= wph_addr;
      buf_lanes <= wph_lanes;
      buf_data  <= i_req.hwdata;
    end
  end

  // --------------------------------------------------
  // Read data, buffered bytes win over RAM
  // --------------------------------------------------
  always_comb begin
    buf_hit = buf_valid && (buf_addr == rd_addr_q);
    for (int i = 0; i < 4; i++) begin
      merged[8*i +: 8] = (buf_hit && buf_lanes[i]) ? buf_data[8*i +: 8]
                                                   : i_rdata[8*i +: 8];
    end
  end

  assign o_rsp.hrdata    = merged;
  assign o_rsp.hreadyout = 1'b1;
  assign o_rsp.hresp     = 1'b0;

  // A read never meets an ending write while the buffer is still full
  assert property (@(posedge clk) disable iff (i_reset)
    (wr_end && buf_valid) |-> !rd_req);

endmodule

`default_nettype wire

// ==== hw/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

  // --------------------------------------------------
  // Memory map
  // --------------------------------------------------
  typedef enum logic [1:0] {
    ITCM = 2'd0,
    DTCM = 2'd1,
    SRAM = 2'd2,
    NONE = 2'd3
  } region_t;

  // Codes of haddr[31:28], each region owns a 256 MB window
  localparam logic [3:0] REGION_ITCM = 4'h0;
  localparam logic [3:0] REGION_DTCM = 4'h2;
  localparam logic [3:0] REGION_SRAM = 4'h6;

  // --------------------------------------------------
  // RAM command
  // --------------------------------------------------
  typedef struct packed {
    logic                       cs;
    logic [3:0]                 wen;
    logic [29:0]                addr;
    logic [ahb_pkg::DATA_W-1:0] wdata;
  } sram_cmd_t;

endpackage

`default_nettype wire

// ==== hw/sram_bank.sv ====
`default_nettype none

module sram_bank #(
  parameter int AW = 12
) (
  input  wire logic                   clk,
  input  wire mem_pkg::sram_cmd_t     i_cmd,
  output logic [ahb_pkg::DATA_W-1:0]  o_rdata
);

  localparam int DEPTH = 2 ** (AW - 2);
  localparam int LANES = ahb_pkg::DATA_W / 8;

  logic [ahb_pkg::DATA_W-1:0] mem [DEPTH];
  logic [AW-3:0]              word_idx;

  // Upper word address bits fold back into the bank
  assign word_idx = i_cmd.addr[AW-3:0];

  always_ff @(posedge clk) begin
    if (i_cmd.cs) begin
      for (int i = 0; i < LANES; i++) begin
        if (i_cmd.wen[i]) begin
          mem[word_idx][8*i +: 8] <= i_cmd.wdata[8*i +: 8];
        end
      end
      // Read only when no lane is written
      if (i_cmd.wen == '0) begin
        o_rdata <= mem[word_idx];
      end
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the AHB memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_ahb_mem_subsys -f ahb_mem_subsys.f -o tb_ahb_mem_subsys

output=$(./obj_dir/tb_ahb_mem_subsys)
echo "$output"

# Pass only when the testbench reports success
echo "$output" | grep -q "All tests passed!"

// ==== sim/tb_ahb_mem_subsys.sv ====
`default_nettype none

module tb_ahb_mem_subsys;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ITCM_AW = 12;
  localparam int DTCM_AW = 12;
  localparam int SRAM_AW = 14;

  // Rough cycle budget of each test
  localparam int LEN_RESET    = 10;
  localparam int LEN_WORD     = 110;
  localparam int LEN_BYTE     = 50;
  localparam int LEN_STREAM   = 150;
  localparam int LEN_REGION   = 15;
  localparam int LEN_UNMAPPED = 25;
  localparam int CYCLE_LIMIT  = 2 * (LEN_RESET + LEN_WORD + LEN_BYTE + LEN_STREAM +
                                     LEN_REGION + LEN_UNMAPPED) + 100;

  // Region 3 stands for an unmapped address
  typedef struct packed {
    logic [1:0]      region;
    logic            write;
    ahb_pkg::hsize_t size;
    logic [31:0]     addr;
    logic [31:0]     data;
  } xfer_t;

  typedef struct packed {
    logic        valid;
    logic        err;
    logic        read;
    logic [31:0] exp_data;
  } dphase_t;

  logic              clk;
  logic              i_reset;
  logic              i_hsel;
  ahb_pkg::ahb_req_t i_ahb;
  ahb_pkg::ahb_rsp_t o_ahb;

  logic [31:0] model_mem [3][4096];
  logic [31:0] known_addr [3][128];
  int          known_cnt [3];
  xfer_t       pending [$];
  dphase_t     dph;
  logic        check_en;
  logic        err_phase2 = 1'b0;
  int          err_count = 0;
  int          check_count = 0;
  int          cycle_count = 0;
  int          test_start_err;
  int          test_start_cycle;
  int          seed_init;

  tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(5)) u_clock_gen (
    .o_clk   (clk),
    .o_reset (i_reset)
  );

  ahb_mem_subsys #(.ITCM_AW(ITCM_AW), .DTCM_AW(DTCM_AW), .SRAM_AW(SRAM_AW)) u_ahb_mem_subsys (
    .clk     (clk),
    .i_reset (i_reset),
    .i_hsel  (i_hsel),
    .i_ahb   (i_ahb),
    .o_ahb   (o_ahb)
  );

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic logic [31:0] region_base(input int r);
    case (r)
      0:       return 32'h0000_0000;
      1:       return 32'h2000_0000;
      default: return 32'h6000_0000;
    endcase
  endfunction

  // Offset bits above the region width alias
  function automatic int word_index(input int r, input logic [31:0] addr);
    int aw;
    aw = (r == 2) ? SRAM_AW : ((r == 1) ? DTCM_AW : ITCM_AW);
    return int'((addr & ((32'd1 << aw) - 32'd1)) >> 2);
  endfunction

  // Naturally aligned lanes covered by a transfer
  function automatic logic [3:0] lane_mask(input ahb_pkg::hsize_t size, input logic [1:0] offs);
    int         nbytes;
    int         first;
    logic [3:0] mask;
    nbytes = 1 << int'(size);
    first  = int'(offs) & ~(nbytes - 1);
    for (int i = 0; i < 4; i++) begin
      mask[i] = (i >= first) && (i < first + nbytes);
    end
    return mask;
  endfunction

  function automatic void model_write(input int r, input logic [31:0] addr,
                                      input ahb_pkg::hsize_t size, input logic [31:0] data);
    logic [3:0] mask;
    int         idx;
    mask = lane_mask(size, addr[1:0]);
    idx  = word_index(r, addr);
    for (int i = 0; i < 4; i++) begin
      if (mask[i]) begin
        model_mem[r][idx][8*i +: 8] = data[8*i +: 8];
      end
    end
  endfunction

  function automatic logic [31:0] ref_read(input int r, input logic [31:0] addr);
    return model_mem[r][word_index(r, addr)];
  endfunction

  // --------------------------------------------------
  // Bus driver
  // --------------------------------------------------
  task automatic queue_xfer(input int r, input logic wr, input ahb_pkg::hsize_t size,
                            input logic [31:0] offs, input logic [31:0] data);
    xfer_t x;
    x.region = 2'(r);
    x.write  = wr;
    x.size   = size;
    x.addr   = (r == 3) ? offs : (region_base(r) | offs);
    x.data   = data;
    pending.push_back(x);
  endtask

  task automatic queue_word_write(input int r, input logic [31:0] offs);
    queue_xfer(r, 1'b1, ahb_pkg::HSIZE_WORD, offs, $urandom);
    if (known_cnt[r] < 128) begin
      known_addr[r][known_cnt[r]] = offs;
      known_cnt[r]++;
    end
  endtask

  task automatic queue_read(input int r, input logic [31:0] offs);
    queue_xfer(r, 1'b0, ahb_pkg::HSIZE_WORD, offs, 32'h0);
  endtask

  task automatic drive_address(input xfer_t x, input logic v);
    i_hsel       = 1'b1;
    i_ahb.haddr  = v ? x.addr : 32'h0;
    i_ahb.htrans = v ? ahb_pkg::HTRANS_NONSEQ : ahb_pkg::HTRANS_IDLE;
    i_ahb.hwrite = v && x.write;
    i_ahb.hsize  = v ? x.size : ahb_pkg::HSIZE_WORD;
  endtask

  // Called right after the edge that accepted x
  task automatic enter_data_phase(input xfer_t x, input logic v);
    dph.valid    = v;
    dph.err      = v && (x.region == 2'd3);
    dph.read     = v && !x.write;
    dph.exp_data = 32'h0;
    i_ahb.hwdata = (v && x.write) ? x.data : 32'h0;
    if (v && x.region != 2'd3) begin
      if (x.write) begin
        model_write(int'(x.region), x.addr, x.size, x.data);
      end else begin
        dph.exp_data = ref_read(int'(x.region), x.addr);
      end
    end
  endtask

  // Pipelined issue, an address phase waits while HREADY is low
  task automatic run_pending();
    xfer_t nxt;
    logic  nxt_valid;
    logic  ready;
    logic  busy;
    nxt       = '0;
    nxt_valid = 1'b0;
    busy      = 1'b1;
    while (busy) begin
      if (!nxt_valid && pending.size() > 0) begin
        nxt       = pending.pop_front();
        nxt_valid = 1'b1;
      end
      drive_address(nxt, nxt_valid);
      @(negedge clk);
      ready = o_ahb.hreadyout;
      @(posedge clk);
      #2;
      if (ready) begin
        enter_data_phase(nxt, nxt_valid);
        nxt_valid = 1'b0;
      end
      busy = nxt_valid || (pending.size() > 0) || dph.valid;
    end
  endtask

  task automatic idle_cycles(input int n);
    xfer_t none;
    none = '0;
    for (int i = 0; i < n; i++) begin
      drive_address(none, 1'b0);
      @(posedge clk);
      #2;
    end
  endtask

  task automatic end_test(input string name);
    $display("Test %s: %0d errors in %0d cycles", name, err_count - test_start_err,
             cycle_count - test_start_cycle);
    test_start_err   = err_count;
    test_start_cycle = cycle_count;
  endtask

  // --------------------------------------------------
  // Response checker, mid-cycle where outputs are settled
  // --------------------------------------------------
  always @(negedge clk) begin
    if (check_en) begin
      check_count++;
      if (dph.valid && dph.err) begin
        if (o_ahb.hreadyout !== err_phase2 || o_ahb.hresp !== 1'b1) begin
          $display("ERROR %0t: error cycle %0d got hreadyout=%b hresp=%b", $time,
                   err_phase2 ? 2 : 1, o_ahb.hreadyout, o_ahb.hresp);
          err_count++;
        end
        err_phase2 = !err_phase2;
      end else begin
        err_phase2 = 1'b0;
        if (o_ahb.hreadyout !== 1'b1 || o_ahb.hresp !== 1'b0) begin
          $display("ERROR %0t: expected zero-wait OKAY, got hreadyout=%b hresp=%b", $time,
                   o_ahb.hreadyout, o_ahb.hresp);
          err_count++;
        end
        if (dph.valid && dph.read && o_ahb.hrdata !== dph.exp_data) begin
          $display("ERROR %0t: read data %h, expected %h", $time, o_ahb.hrdata, dph.exp_data);
          err_count++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failures found");
      $finish;
    end
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    int          r;
    int          op;
    logic [31:0] offs;
    seed_init = $urandom(32'h7987);
    i_hsel    = 1'b0;
    i_ahb     = '0;
    dph       = '0;
    check_en  = 1'b0;
    for (int i = 0; i < 3; i++) begin
      known_cnt[i] = 0;
    end
    wait (i_reset == 1'b0);
    check_en         = 1'b1;
    test_start_err   = 0;
    test_start_cycle = cycle_count;

    idle_cycles(LEN_RESET);
    end_test("reset_state");

    for (int k = 0; k < 3; k++) begin
      for (int n = 0; n < 16; n++) begin
        queue_word_write(k, $urandom & 32'h0FFF_FFFC);
      end
      for (int n = 0; n < 16; n++) begin
        queue_read(k, known_addr[k][known_cnt[k] - 1 - n]);
      end
    end
    run_pending();
    end_test("word_rw");

    for (int k = 0; k < 3; k++) begin
      offs = $urandom & 32'h0FFF_FFFC;
      queue_word_write(k, offs);
      for (int lane = 0; lane < 4; lane++) begin
        queue_xfer(k, 1'b1, ahb_pkg::HSIZE_BYTE, offs + lane, $urandom);
        queue_read(k, offs);
      end
      for (int half = 0; half < 4; half += 2) begin
        queue_xfer(k, 1'b1, ahb_pkg::HSIZE_HALF, offs + half, $urandom);
        queue_read(k, offs);
      end
    end
    run_pending();
    end_test("byte_half");

    // Reads right behind writes hit the write buffer
    for (int k = 0; k < 3; k++) begin
      for (int n = 0; n < 8; n++) begin
        offs = $urandom & 32'h0FFF_FFFC;
        queue_word_write(k, offs);
        queue_read(k, offs);
        queue_xfer(k, 1'b1, ahb_pkg::HSIZE_BYTE, offs + (n % 4), $urandom);
        queue_read(k, offs);
      end
    end
    for (int n = 0; n < 40; n++) begin
      r    = $urandom % 3;
      offs = known_addr[r][$urandom % known_cnt[r]];
      op   = $urandom % 4;
      case (op)
        0:       queue_read(r, offs);
        1:       queue_xfer(r, 1'b1, ahb_pkg::HSIZE_WORD, offs, $urandom);
        2:       queue_xfer(r, 1'b1, ahb_pkg::HSIZE_BYTE, offs + ($urandom % 4), $urandom);
        default: queue_xfer(r, 1'b1, ahb_pkg::HSIZE_HALF, offs + 2 * ($urandom % 2), $urandom);
      endcase
    end
    run_pending();
    end_test("back_to_back");

    offs = $urandom & 32'h0FFF_FFFC;
    for (int k = 0; k < 3; k++) begin
      queue_xfer(k, 1'b1, ahb_pkg::HSIZE_WORD, offs, {8'(k + 1), 24'($urandom)});
    end
    for (int k = 0; k < 3; k++) begin
      queue_read(k, offs);
    end
    run_pending();
    end_test("region_split");

    queue_xfer(0, 1'b1, ahb_pkg::HSIZE_WORD, known_addr[0][0], $urandom);
    queue_xfer(3, 1'b0, ahb_pkg::HSIZE_WORD, 32'h4000_0010, 32'h0);
    queue_read(0, known_addr[0][0]);
    queue_xfer(3, 1'b1, ahb_pkg::HSIZE_WORD, 32'hF000_0000, $urandom);
    queue_xfer(3, 1'b0, ahb_pkg::HSIZE_WORD, 32'h1000_0004, 32'h0);
    queue_read(1, known_addr[1][0]);
    queue_xfer(2, 1'b1, ahb_pkg::HSIZE_WORD, known_addr[2][0], $urandom);
    queue_xfer(3, 1'b0, ahb_pkg::HSIZE_BYTE, 32'h8000_0003, 32'h0);
    queue_read(2, known_addr[2][0]);
    run_pending();
    idle_cycles(3);
    end_test("unmapped");

    $display("Summary: %0d checks, %0d errors", check_count, err_count);
    if (err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 5
) (
  output logic o_clk,
  output logic o_reset
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // Released just after a rising edge, like every other input
  initial begin
    o_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #2;
    o_reset = 1'b0;
  end

endmodule

`default_nettype wire
